// File: rtl/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// Cache geometry
`define ICACHE_SETS         8
`define ICACHE_WAYS         4
`define ICACHE_BLOCK_WORDS  4

// Burst memory
`define MEM_WORDS           1024
`define MEM_LATENCY         6

// Address fields, 2 byte bits below the word offset
`define ICACHE_OFF_BITS     2
`define ICACHE_SET_BITS     3
`define ICACHE_TAG_BITS     (32 - `ICACHE_SET_BITS - `ICACHE_OFF_BITS - 2)

`endif

// File: rtl/icache_pkg.sv
`default_nettype none

`include "icache_defines.svh"

package icache_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [`ICACHE_TAG_BITS-1:0] tag_t;
    typedef logic [`ICACHE_SET_BITS-1:0] set_idx_t;
    typedef logic [`ICACHE_OFF_BITS-1:0] word_off_t;
    typedef logic [1:0] way_t;

    typedef enum logic [1:0] {
        SRC_HIT,
        SRC_PREFETCH,
        SRC_MISS
    } fetch_src_e;

    typedef struct packed {
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        addr_t      addr;
        instr_t     instr;
        fetch_src_e src;
    } fetch_rsp_t;

    typedef struct packed {
        addr_t     block_addr;
        word_off_t crit;
        logic      is_prefetch;
    } mem_req_t;

    typedef struct packed {
        instr_t    data;
        word_off_t off;
    } mem_beat_t;

    typedef struct packed {
        set_idx_t                              set;
        tag_t                                  tag;
        instr_t [`ICACHE_BLOCK_WORDS-1:0] words;
    } fill_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_DEMAND,
        WAIT_PREFETCH,
        MOVE_PF
    } refill_state_e;

endpackage

`default_nettype wire

// File: rtl/icache_store.sv
`default_nettype none
`timescale 1ns/1ps

`include "icache_defines.svh"

module icache_store (
    input  logic                                        Clk,
    input  logic                                        rst,
    input  icache_pkg::addr_t                           lookup_addr,
    output logic                                        hit,
    output icache_pkg::way_t                            hit_way,
    output icache_pkg::instr_t [`ICACHE_BLOCK_WORDS-1:0] hit_words,
    input  logic                                        fill_valid,
    input  icache_pkg::fill_t                           fill
);

    // Lowest bit of the set index
    localparam int SB = `ICACHE_OFF_BITS + 2;

    icache_pkg::tag_t                            tag_q   [`ICACHE_SETS][`ICACHE_WAYS];
    icache_pkg::instr_t [`ICACHE_BLOCK_WORDS-1:0] data_q  [`ICACHE_SETS][`ICACHE_WAYS];
    logic [`ICACHE_WAYS-1:0]                     valid_q [`ICACHE_SETS];
    icache_pkg::way_t                            rr_q    [`ICACHE_SETS];

    icache_pkg::set_idx_t    lk_set;
    icache_pkg::tag_t        lk_tag;
    logic [`ICACHE_WAYS-1:0] match;
    icache_pkg::way_t        victim;

    assign lk_set = lookup_addr[SB +: `ICACHE_SET_BITS];
    assign lk_tag = lookup_addr[31 -: `ICACHE_TAG_BITS];

    // Tag compare across all ways of the set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            match[w] = valid_q[lk_set][w] && (tag_q[lk_set][w] == lk_tag);
            if (match[w]) begin
                hit     = 1'b1;
                hit_way = icache_pkg::way_t'(w);
            end
        end
        hit_words = data_q[lk_set][hit_way];
    end

    // First invalid way wins, else round robin
    always_comb begin
        victim = rr_q[fill.set];
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[fill.set][w]) begin
                victim = icache_pkg::way_t'(w);
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                valid_q[s] <= '0;
                rr_q[s]    <= '0;
            end
        end else if (fill_valid) begin
            valid_q[fill.set][victim] <= 1'b1;
            rr_q[fill.set]            <= rr_q[fill.set] + 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (fill_valid) begin
            tag_q[fill.set][victim]  <= fill.tag;
            data_q[fill.set][victim] <= fill.words;
        end
    end

    // The controller never fills a block that is already present
    assert property (@(posedge Clk) disable iff (rst) $onehot0(match))
        else $error("more than one way matches the lookup tag");

endmodule

`default_nettype wire

// File: rtl/prefetch_buf.sv
`default_nettype none
`timescale 1ns/1ps

`include "icache_defines.svh"

module prefetch_buf (
    input  logic                                        Clk,
    input  logic                                        rst,
    input  logic                                        pf_start,
    input  icache_pkg::addr_t                           pf_addr,
    input  logic                                        pf_beat_valid,
    input  icache_pkg::mem_beat_t                       pf_beat,
    input  logic                                        pf_cancel,
    input  logic                                        pf_take,
    input  icache_pkg::addr_t                           lookup_addr,
    output logic                                        pf_hit,
    output icache_pkg::instr_t [`ICACHE_BLOCK_WORDS-1:0] pf_words
);

    localparam int SB = `ICACHE_OFF_BITS + 2;

    icache_pkg::addr_t                           addr_q;
    icache_pkg::instr_t [`ICACHE_BLOCK_WORDS-1:0] words_q;
    icache_pkg::word_off_t                       cnt_q;
    logic                                        valid_q;

    assign pf_hit   = valid_q && (lookup_addr[31:SB] == addr_q[31:SB]);
    assign pf_words = words_q;

    always_ff @(posedge Clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            cnt_q   <= '0;
        end else if (pf_start) begin
            valid_q <= 1'b0;
            cnt_q   <= '0;
        end else begin
            if (pf_cancel || pf_take) begin
                valid_q <= 1'b0;
            end
            if (pf_beat_valid) begin
                cnt_q <= cnt_q + 1'b1;
                // Block complete after the last beat
                if (cnt_q == icache_pkg::word_off_t'(`ICACHE_BLOCK_WORDS - 1)) begin
                    valid_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (pf_start) begin
            addr_q <= pf_addr;
        end
        if (pf_beat_valid) begin
            words_q[pf_beat.off] <= pf_beat.data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/burst_mem.sv
`default_nettype none
`timescale 1ns/1ps

`include "icache_defines.svh"

module burst_mem (
    input  logic                  Clk,
    input  logic                  rst,
    input  logic                  mem_req_valid,
    input  icache_pkg::mem_req_t  mem_req,
    output logic                  mem_busy,
    output logic                  mem_beat_valid,
    output icache_pkg::mem_beat_t mem_beat,
    input  logic                  load_valid,
    input  icache_pkg::addr_t     load_addr,
    input  icache_pkg::instr_t    load_data
);

    localparam int AW = $clog2(`MEM_WORDS);
    localparam int LW = $clog2(`MEM_LATENCY + 1);
    localparam int SB = `ICACHE_OFF_BITS + 2;

    icache_pkg::instr_t mem [`MEM_WORDS];

    icache_pkg::mem_req_t  req_q;
    logic                  busy_q;
    logic [LW-1:0]         lat_q;
    icache_pkg::word_off_t beat_q;
    icache_pkg::word_off_t beat_off;

    // Wrapped burst order starting at the critical word
    assign beat_off       = req_q.crit + beat_q;
    assign mem_busy       = busy_q;
    assign mem_beat_valid = busy_q && (lat_q == '0);
    assign mem_beat.off   = beat_off;
    assign mem_beat.data  = mem[{req_q.block_addr[AW+1:SB], beat_off}];

    always_ff @(posedge Clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            lat_q  <= '0;
            beat_q <= '0;
        end else if (mem_req_valid) begin
            busy_q <= 1'b1;
            lat_q  <= LW'(`MEM_LATENCY - 1);
            beat_q <= '0;
        end else if (busy_q) begin
            if (lat_q != '0) begin
                lat_q <= lat_q - 1'b1;
            end else begin
                beat_q <= beat_q + 1'b1;
                if (beat_q == icache_pkg::word_off_t'(`ICACHE_BLOCK_WORDS - 1)) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (mem_req_valid) begin
            req_q <= mem_req;
        end
    end

    // Load port stands in for the rest of the system
    always_ff @(posedge Clk) begin
        if (load_valid) begin
            mem[load_addr[AW+1:2]] <= load_data;
        end
    end

    assert property (@(posedge Clk) disable iff (rst) mem_req_valid |-> !mem_busy)
        else $error("memory request while a burst is in progress");

endmodule

`default_nettype wire

// File: rtl/icache_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

`include "icache_defines.svh"

module icache_ctrl (
    input  logic                                        Clk,
    input  logic                                        rst,
    input  logic                                        fetch_valid,
    input  icache_pkg::fetch_req_t                      fetch_req,
    input  logic                                        flush,
    output logic                                        rsp_valid,
    output icache_pkg::fetch_rsp_t                      rsp,
    output logic                                        busy,
    output icache_pkg::addr_t                           lookup_addr,
    input  logic                                        hit,
    input  icache_pkg::way_t                            hit_way,
    input  icache_pkg::instr_t [`ICACHE_BLOCK_WORDS-1:0] hit_words,
    output logic                                        fill_valid,
    output icache_pkg::fill_t                           fill,
    output logic                                        pf_start,
    output icache_pkg::addr_t                           pf_addr,
    output logic                                        pf_beat_valid,
    output logic                                        pf_cancel,
    output logic                                        pf_take,
    input  logic                                        pf_hit,
    input  icache_pkg::instr_t [`ICACHE_BLOCK_WORDS-1:0] pf_words,
    output logic                                        mem_req_valid,
    output icache_pkg::mem_req_t                        mem_req,
    input  logic                                        mem_busy,
    input  logic                                        mem_beat_valid,
    input  icache_pkg::mem_beat_t                       mem_beat
);

    localparam int SB = `ICACHE_OFF_BITS + 2;

    icache_pkg::refill_state_e                   state_q;
    icache_pkg::addr_t                           req_q;
    icache_pkg::instr_t [`ICACHE_BLOCK_WORDS-1:0] words_q;
    icache_pkg::word_off_t                       beat_cnt_q;
    logic                                        fill_q;
    logic                                        pf_pending_q;
    logic                                        sent_q;
    logic                                        drop_q;
    logic                                        burst_pf_q;

    logic                  accept;
    logic                  fwd_hit;
    logic                  demand_req;
    logic                  demand_beat;
    logic                  pf_launch;
    logic                  pf_busy;
    icache_pkg::addr_t     next_blk;
    icache_pkg::word_off_t req_off;

    assign accept   = fetch_valid && !flush && (state_q == icache_pkg::IDLE);
    assign req_off  = fetch_req.addr[SB-1:2];
    assign next_blk = {req_q[31:SB], {SB{1'b0}}} + 32'(`ICACHE_BLOCK_WORDS * 4);
    // Block being written this cycle is not in the store yet
    assign fwd_hit  = fill_q && (fetch_req.addr[31:SB] == req_q[31:SB]);

    assign demand_req  = (state_q == icache_pkg::WAIT_DEMAND) && !sent_q && !mem_busy;
    assign demand_beat = (state_q == icache_pkg::WAIT_DEMAND) && mem_beat_valid && !burst_pf_q;
    assign pf_launch   = pf_pending_q && !flush && !mem_busy && (state_q == icache_pkg::IDLE);
    assign pf_busy     = (burst_pf_q && mem_busy) || pf_launch;

    assign busy          = (state_q != icache_pkg::IDLE);
    assign pf_start      = pf_launch;
    assign pf_addr       = next_blk;
    assign pf_beat_valid = mem_beat_valid && burst_pf_q;
    assign pf_cancel     = flush && pf_pending_q && (state_q == icache_pkg::IDLE);
    assign pf_take       = accept && !hit && !fwd_hit && pf_hit;

    assign fill_valid = fill_q || (state_q == icache_pkg::MOVE_PF);
    assign fill.set   = req_q[SB +: `ICACHE_SET_BITS];
    assign fill.tag   = req_q[31 -: `ICACHE_TAG_BITS];
    assign fill.words = words_q;

    // In the fill cycle an idle lookup port checks the next block
    always_comb begin
        if (state_q != icache_pkg::IDLE) begin
            lookup_addr = req_q;
        end else if (fill_q && !fetch_valid) begin
            lookup_addr = next_blk;
        end else begin
            lookup_addr = fetch_req.addr;
        end
    end

    always_comb begin
        mem_req_valid       = demand_req || pf_launch;
        mem_req.is_prefetch = !demand_req;
        mem_req.block_addr  = demand_req ? {req_q[31:SB], {SB{1'b0}}} : next_blk;
        mem_req.crit        = demand_req ? req_q[SB-1:2] : '0;
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            state_q      <= icache_pkg::IDLE;
            rsp_valid    <= 1'b0;
            fill_q       <= 1'b0;
            pf_pending_q <= 1'b0;
            sent_q       <= 1'b0;
            drop_q       <= 1'b0;
            burst_pf_q   <= 1'b0;
            beat_cnt_q   <= '0;
        end else begin
            rsp_valid    <= 1'b0;
            fill_q       <= 1'b0;
            pf_pending_q <= 1'b0;
            if (mem_req_valid) begin
                burst_pf_q <= mem_req.is_prefetch;
            end
            if (demand_req) begin
                sent_q <= 1'b1;
            end
            if (flush) begin
                drop_q <= 1'b1;
            end
            case (state_q)
                icache_pkg::IDLE: begin
                    if (fill_q && !fetch_valid && !hit && !pf_hit && !flush) begin
                        pf_pending_q <= 1'b1;
                    end
                    if (accept) begin
                        if (hit || fwd_hit) begin
                            rsp_valid <= 1'b1;
                        end else if (pf_hit) begin
                            rsp_valid <= 1'b1;
                            state_q   <= icache_pkg::MOVE_PF;
                        end else begin
                            state_q    <= pf_busy ? icache_pkg::WAIT_PREFETCH
                                                  : icache_pkg::WAIT_DEMAND;
                            sent_q     <= 1'b0;
                            drop_q     <= 1'b0;
                            beat_cnt_q <= '0;
                        end
                    end
                end
                icache_pkg::WAIT_PREFETCH: begin
                    // Prefetch burst cannot be interrupted
                    if (!mem_busy) begin
                        state_q <= icache_pkg::WAIT_DEMAND;
                    end
                end
                icache_pkg::WAIT_DEMAND: begin
                    if (demand_beat) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (mem_beat.off == req_q[SB-1:2] && !drop_q && !flush) begin
                            rsp_valid <= 1'b1;
                        end
                        if (beat_cnt_q == icache_pkg::word_off_t'(`ICACHE_BLOCK_WORDS - 1)) begin
                            state_q <= icache_pkg::IDLE;
                            fill_q  <= 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= icache_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) begin
            req_q    <= fetch_req.addr;
            rsp.addr <= fetch_req.addr;
            if (hit) begin
                rsp.instr <= hit_words[req_off];
                rsp.src   <= icache_pkg::SRC_HIT;
            end else if (fwd_hit) begin
                rsp.instr <= words_q[req_off];
                rsp.src   <= icache_pkg::SRC_HIT;
            end else begin
                rsp.instr <= pf_words[req_off];
                rsp.src   <= icache_pkg::SRC_PREFETCH;
            end
        end else if (demand_beat && mem_beat.off == req_q[SB-1:2]) begin
            // Critical word goes straight to the core
            rsp.addr  <= req_q;
            rsp.instr <= mem_beat.data;
            rsp.src   <= icache_pkg::SRC_MISS;
        end
        if (pf_take) begin
            words_q <= pf_words;
        end else if (demand_beat) begin
            words_q[mem_beat.off] <= mem_beat.data;
        end
    end

    assert property (@(posedge Clk) disable iff (rst) fetch_valid |-> !busy)
        else $error("fetch_valid raised while busy");

endmodule

`default_nettype wire

// File: rtl/fetch_subsys.sv
`default_nettype none
`timescale 1ns/1ps

`include "icache_defines.svh"

module fetch_subsys (
    input  logic                   Clk,
    input  logic                   rst,
    input  logic                   fetch_valid,
    input  icache_pkg::fetch_req_t fetch_req,
    input  logic                   flush,
    output logic                   rsp_valid,
    output icache_pkg::fetch_rsp_t rsp,
    output logic                   busy,
    input  logic                   load_valid,
    input  icache_pkg::addr_t      load_addr,
    input  icache_pkg::instr_t     load_data
);

    // Store and prefetch lookup
    icache_pkg::addr_t                           lookup_addr;
    logic                                        hit;
    icache_pkg::way_t                            hit_way;
    icache_pkg::instr_t [`ICACHE_BLOCK_WORDS-1:0] hit_words;
    logic                                        fill_valid;
    icache_pkg::fill_t                           fill;

    // Prefetch buffer control
    logic                                        pf_start;
    icache_pkg::addr_t                           pf_addr;
    logic                                        pf_beat_valid;
    logic                                        pf_cancel;
    logic                                        pf_take;
    logic                                        pf_hit;
    icache_pkg::instr_t [`ICACHE_BLOCK_WORDS-1:0] pf_words;

    // Burst memory
    logic                  mem_req_valid;
    icache_pkg::mem_req_t  mem_req;
    logic                  mem_busy;
    logic                  mem_beat_valid;
    icache_pkg::mem_beat_t mem_beat;

    icache_ctrl icache_ctrl_i (.*);

    icache_store icache_store_i (.*);

    prefetch_buf prefetch_buf_i (
        .pf_beat(mem_beat),
        .*
    );

    burst_mem burst_mem_i (.*);

endmodule

`default_nettype wire

// File: tests/fetch_subsys_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "icache_defines.svh"

module fetch_subsys_tb;

    localparam int WAIT_LIMIT = 200;
    localparam int PRELOAD_WORDS = 256;
    // Prefetch request, memory latency, four beats and some margin
    localparam int PF_WAIT = `MEM_LATENCY + `ICACHE_BLOCK_WORDS + 4;

    logic                   Clk;
    logic                   rst;
    logic                   fetch_valid;
    icache_pkg::fetch_req_t fetch_req;
    logic                   flush;
    logic                   rsp_valid;
    icache_pkg::fetch_rsp_t rsp;
    logic                   busy;
    logic                   load_valid;
    icache_pkg::addr_t      load_addr;
    icache_pkg::instr_t     load_data;

    icache_pkg::instr_t     mirror [PRELOAD_WORDS];
    logic [31:0]            lfsr_q;
    int                     rst_cycles = 0;

    // Request the checks expect an answer for
    logic                   open_req;
    icache_pkg::addr_t      open_addr;
    logic                   src_known;
    icache_pkg::fetch_src_e exp_src;

    fetch_subsys fetch_subsys_i (.*);

    always #20 Clk = ~Clk;

    always @(posedge Clk) begin
        if (rst) begin
            rst_cycles <= rst_cycles + 1;
        end
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on the first error");
    endtask

    function automatic icache_pkg::instr_t mirror_word(input icache_pkg::addr_t a);
        return mirror[a[9:2]];
    endfunction

    // Fibonacci LFSR with taps 32, 22, 2, 1, one step per bit
    function automatic logic [31:0] lfsr_take(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            bits   = {bits[30:0], lfsr_q[0]};
        end
        return bits;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge Clk);
            #2;
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < WAIT_LIMIT) begin
            n++;
            @(posedge Clk);
            #2;
        end
        if (busy) begin
            stop_run("busy stayed high longer than the wait limit");
        end
    endtask

    task automatic preload_memory();
        icache_pkg::instr_t w;
        for (int i = 0; i < PRELOAD_WORDS; i++) begin
            w          = lfsr_take(32);
            mirror[i]  = w;
            load_valid = 1'b1;
            load_addr  = icache_pkg::addr_t'(i * 4);
            load_data  = w;
            @(posedge Clk);
            #2;
        end
        load_valid = 1'b0;
    endtask

    task automatic start_fetch(input icache_pkg::addr_t a, input logic known,
                               input icache_pkg::fetch_src_e src);
        wait_idle();
        fetch_req.addr = a;
        fetch_valid    = 1'b1;
        open_req       = 1'b1;
        open_addr      = a;
        src_known      = known;
        exp_src        = src;
        @(posedge Clk);
        #2;
        fetch_valid = 1'b0;
    endtask

    task automatic issue_fetch(input icache_pkg::addr_t a, input logic known,
                               input icache_pkg::fetch_src_e src);
        int n;
        n = 0;
        start_fetch(a, known, src);
        while (!rsp_valid && n < WAIT_LIMIT) begin
            n++;
            @(posedge Clk);
            #2;
        end
        if (!rsp_valid) begin
            stop_run($sformatf("no response to the fetch of address %h", a));
        end else begin
            // The checks sample the response at the next edge
            @(posedge Clk);
            #2;
            open_req = 1'b0;
        end
    endtask

    // Cold miss that the core abandons before the critical word
    task automatic flush_miss(input icache_pkg::addr_t a);
        int n;
        n = 0;
        start_fetch(a, 1'b1, icache_pkg::SRC_MISS);
        while (!busy && n < WAIT_LIMIT) begin
            n++;
            @(posedge Clk);
            #2;
        end
        if (!busy) begin
            stop_run($sformatf("the miss on address %h never raised busy", a));
        end else begin
            flush    = 1'b1;
            open_req = 1'b0;
            @(posedge Clk);
            #2;
            flush = 1'b0;
            wait_idle();
            idle_cycles(2);
        end
    endtask

    reset_check: assert property (@(posedge Clk)
        rst && rst_cycles != 0 |-> !busy && !rsp_valid)
        else stop_run($sformatf("ERROR at %0t: busy or rsp_valid high during reset", $time));

    data_check: assert property (@(posedge Clk) disable iff (rst)
        rsp_valid |-> rsp.instr == mirror_word(rsp.addr))
        else stop_run($sformatf("ERROR at %0t: instr %h for address %h, expected %h",
            $time, $sampled(rsp.instr), $sampled(rsp.addr), mirror_word($sampled(rsp.addr))));

    addr_check: assert property (@(posedge Clk) disable iff (rst)
        rsp_valid |-> open_req && rsp.addr == open_addr)
        else stop_run($sformatf("ERROR at %0t: response for %h, open %b for %h",
            $time, $sampled(rsp.addr), $sampled(open_req), $sampled(open_addr)));

    src_check: assert property (@(posedge Clk) disable iff (rst)
        rsp_valid && src_known |-> rsp.src == exp_src)
        else stop_run($sformatf("ERROR at %0t: source %0d for address %h, expected %0d",
            $time, $sampled(rsp.src), $sampled(rsp.addr), $sampled(exp_src)));

    // Hits from the store or the buffer answer in the next cycle
    latency_check: assert property (@(posedge Clk) disable iff (rst)
        $past(fetch_valid) && src_known && exp_src != icache_pkg::SRC_MISS |-> rsp_valid)
        else stop_run($sformatf("ERROR at %0t: no response one cycle after fetch of %h",
            $time, $sampled(open_addr)));

    crit_first_check: assert property (@(posedge Clk) disable iff (rst)
        rsp_valid && rsp.src == icache_pkg::SRC_MISS |-> busy)
        else stop_run($sformatf("ERROR at %0t: miss answered after the refill ended", $time));

    initial begin
        Clk         = 1'b0;
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch_req   = '0;
        flush       = 1'b0;
        load_valid  = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        open_req    = 1'b0;
        open_addr   = '0;
        src_known   = 1'b0;
        exp_src     = icache_pkg::SRC_MISS;
        lfsr_q      = 32'h1f4f_dc2f;

        repeat (5) @(posedge Clk);
        #2;
        rst = 1'b0;
        preload_memory();

        // Third word of block 0, cold after reset
        issue_fetch(32'h008, 1'b1, icache_pkg::SRC_MISS);
        wait_idle();
        idle_cycles(PF_WAIT);

        // Block 1 was prefetched, then moves into the store
        issue_fetch(32'h014, 1'b1, icache_pkg::SRC_PREFETCH);
        issue_fetch(32'h014, 1'b1, icache_pkg::SRC_HIT);
        issue_fetch(32'h01c, 1'b1, icache_pkg::SRC_HIT);
        issue_fetch(32'h008, 1'b1, icache_pkg::SRC_HIT);

        // Four blocks of set 3 fit without eviction
        for (int i = 0; i < 4; i++) begin
            issue_fetch(32'h030 + i * 32'h80, 1'b1, icache_pkg::SRC_MISS);
        end
        for (int i = 0; i < 4; i++) begin
            issue_fetch(32'h034 + i * 32'h80, 1'b1, icache_pkg::SRC_HIT);
        end

        flush_miss(32'h204);
        issue_fetch(32'h204, 1'b1, icache_pkg::SRC_HIT);

        // Random word fetches over the preloaded range
        for (int i = 0; i < 48; i++) begin
            issue_fetch({22'b0, 8'(lfsr_take(8)), 2'b00}, 1'b0, icache_pkg::SRC_HIT);
        end
        wait_idle();
        idle_cycles(4);

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: fetch_subsys.f
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_store.sv
rtl/prefetch_buf.sv
rtl/burst_mem.sv
rtl/icache_ctrl.sv
rtl/fetch_subsys.sv
tests/fetch_subsys_tb.sv

// File: Makefile
TOP := fetch_subsys_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build folder"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f fetch_subsys.f \
		--top-module $(TOP) --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
